/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - files:
      - hdl/fetch_pkg.sv
      - hdl/fetch_slot_if.sv
      - hdl/fetch_predictor.sv
      - hdl/fetch_npc.sv
      - hdl/fetch_align.sv
      - hdl/fetch_frontend.sv
  - target: test
    files:
      - tb/fetch_frontend_properties.sv
      - tb/fetch_frontend_tb.sv

/* all.f */
hdl/fetch_pkg.sv
hdl/fetch_slot_if.sv
hdl/fetch_predictor.sv
hdl/fetch_npc.sv
hdl/fetch_align.sv
hdl/fetch_frontend.sv
tb/fetch_frontend_properties.sv
tb/fetch_frontend_tb.sv

/* hdl/fetch_align.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_align #(
  parameter int unsigned AddrLen = fetch_pkg::AddrLen
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  fetch_slot_if.align              slot,
  input  logic                     imem_resp_valid_i,
  input  logic [31:0]              imem_resp_instr_i,
  input  logic                     flush_i,
  output logic                     fetch_valid_o,
  input  logic                     fetch_ready_i,
  output logic [AddrLen-1:0]       fetch_pc_o,
  output logic [31:0]              fetch_instr_o,
  output fetch_pkg::fetch_reason_e fetch_reason_o
);

  import fetch_pkg::*;

  logic               boot_q;
  logic               flush_q;
  logic               kill;
  logic               buf_valid_q;
  fetch_word_u        buf_q;
  fetch_word_u        resp_word;
  fetch_word_u        word;
  logic               word_valid;
  logic               left_valid_q;
  logic               left_valid_d;
  logic [15:0]        left_half_q;
  logic [AddrLen-1:0] left_pc_q;
  fetch_reason_e      left_reason_q;
  logic               use_left;
  logic               second_q;
  logic               second_d;
  logic               keep_left;
  logic               done;
  fetch_reason_e      upper_reason;
  logic [AddrLen-1:0] lower_pc;
  logic [AddrLen-1:0] upper_pc;

  // The first edge after reset forces a flush, which fetches the reset vector.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_q  <= 1'b0;
      flush_q <= 1'b0;
    end else begin
      boot_q  <= 1'b1;
      flush_q <= flush_i || !boot_q;
    end
  end

  // Anything that arrives while flushing belongs to the old stream.
  assign kill = flush_i || flush_q;

  assign resp_word.word = imem_resp_instr_i;
  assign word       = buf_valid_q ? buf_q : resp_word;
  assign word_valid = slot.slot_valid && !kill && (buf_valid_q || imem_resp_valid_i);
  assign lower_pc   = {slot.slot_pc[AddrLen-1:2], 2'b00};
  assign upper_pc   = {slot.slot_pc[AddrLen-1:2], 2'b10};

  // A left-over half only joins a word that follows it in sequence.
  assign use_left = left_valid_q && slot.slot_reason == FETCH_PREFETCH;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction split
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    fetch_valid_o  = 1'b0;
    fetch_pc_o     = '0;
    fetch_instr_o  = '0;
    fetch_reason_o = FETCH_PREFETCH;
    upper_reason   = FETCH_PREFETCH;
    second_d       = second_q;
    left_valid_d   = left_valid_q;
    keep_left      = 1'b0;
    done           = 1'b0;

    if (word_valid) begin
      if (slot.slot_strb == 2'b10 || second_q) begin
        if (!second_q) begin
          upper_reason = slot.slot_reason;
        end
        if (is_full_instr(word.half.upper)) begin
          // Only the first half is here, so keep it and move on silently.
          keep_left = 1'b1;
          done      = 1'b1;
        end else begin
          fetch_valid_o  = 1'b1;
          fetch_pc_o     = upper_pc;
          fetch_instr_o  = {16'h0000, word.half.upper};
          fetch_reason_o = upper_reason;
          done           = fetch_ready_i;
        end
      end else begin
        fetch_valid_o = 1'b1;
        if (use_left) begin
          fetch_pc_o     = left_pc_q;
          fetch_instr_o  = {word.half.lower, left_half_q};
          fetch_reason_o = left_reason_q;
        end else if (is_full_instr(word.half.lower)) begin
          fetch_pc_o     = lower_pc;
          fetch_instr_o  = word.word;
          fetch_reason_o = slot.slot_reason;
        end else begin
          fetch_pc_o     = lower_pc;
          fetch_instr_o  = {16'h0000, word.half.lower};
          fetch_reason_o = slot.slot_reason;
        end

        // Once this one is taken, look at what starts in the upper half.
        if (fetch_ready_i) begin
          left_valid_d = 1'b0;
          if (!use_left && is_full_instr(word.half.lower)) begin
            done = 1'b1;
          end else if (!slot.slot_strb[1]) begin
            done = 1'b1;
          end else if (is_full_instr(word.half.upper)) begin
            keep_left = 1'b1;
            done      = 1'b1;
          end else begin
            second_d = 1'b1;
          end
        end
      end
    end

    if (done) begin
      second_d     = 1'b0;
      left_valid_d = keep_left;
    end
  end

  assign slot.slot_ready = flush_q || done;

  ////////////////////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_valid_q  <= 1'b0;
      left_valid_q <= 1'b0;
      second_q     <= 1'b0;
    end else if (kill) begin
      buf_valid_q  <= 1'b0;
      left_valid_q <= 1'b0;
      second_q     <= 1'b0;
    end else begin
      left_valid_q <= left_valid_d;
      second_q     <= second_d;
      if (done) begin
        buf_valid_q <= 1'b0;
      end else if (word_valid) begin
        buf_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_valid && !buf_valid_q && !done) begin
      buf_q <= resp_word;
    end
    if (keep_left) begin
      left_half_q   <= word.half.upper;
      left_pc_q     <= upper_pc;
      left_reason_q <= upper_reason;
    end
  end

endmodule

`default_nettype wire

/* hdl/fetch_frontend.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_frontend #(
  parameter int unsigned AddrLen       = fetch_pkg::AddrLen,
  parameter int unsigned BtbIndexWidth = fetch_pkg::BtbIndexWidth,
  parameter int unsigned BhtIndexWidth = fetch_pkg::BhtIndexWidth
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  output logic                     imem_req_valid_o,
  output logic [AddrLen-1:0]       imem_req_pc_o,
  input  logic                     imem_resp_valid_i,
  input  logic [31:0]              imem_resp_instr_i,

  input  logic                     redirect_valid_i,
  input  logic [AddrLen-1:0]       redirect_pc_i,
  input  fetch_pkg::branch_type_e  branch_type_i,
  input  logic [AddrLen-1:0]       branch_pc_i,

  output logic                     fetch_valid_o,
  input  logic                     fetch_ready_i,
  output logic [AddrLen-1:0]       fetch_pc_o,
  output logic [31:0]              fetch_instr_o,
  output fetch_pkg::fetch_reason_e fetch_reason_o
);

  logic [AddrLen-1:0] next_pc;
  logic               predict_taken;
  logic [AddrLen-1:0] predict_target;
  logic               predict_partial;

  fetch_slot_if #(.AddrLen(AddrLen)) slot_if ();

  fetch_npc #(
    .AddrLen (AddrLen)
  ) fetch_npc_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .redirect_valid_i  (redirect_valid_i),
    .redirect_pc_i     (redirect_pc_i),
    .predict_taken_i   (predict_taken),
    .predict_target_i  (predict_target),
    .predict_partial_i (predict_partial),
    .slot              (slot_if),
    .npc_o             (next_pc),
    .imem_req_valid_o  (imem_req_valid_o),
    .imem_req_pc_o     (imem_req_pc_o)
  );

  // The lookup follows the slot, so it is taken on every advance.
  fetch_predictor #(
    .AddrLen       (AddrLen),
    .BtbIndexWidth (BtbIndexWidth),
    .BhtIndexWidth (BhtIndexWidth)
  ) fetch_predictor_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lookup_valid_i    (slot_if.slot_ready),
    .lookup_pc_i       (next_pc),
    .slot_pc_i         (slot_if.slot_pc),
    .branch_type_i     (branch_type_i),
    .branch_pc_i       (branch_pc_i),
    .redirect_pc_i     (redirect_pc_i),
    .predict_taken_o   (predict_taken),
    .predict_target_o  (predict_target),
    .predict_partial_o (predict_partial)
  );

  fetch_align #(
    .AddrLen (AddrLen)
  ) fetch_align_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .slot              (slot_if),
    .imem_resp_valid_i (imem_resp_valid_i),
    .imem_resp_instr_i (imem_resp_instr_i),
    .flush_i           (redirect_valid_i),
    .fetch_valid_o     (fetch_valid_o),
    .fetch_ready_i     (fetch_ready_i),
    .fetch_pc_o        (fetch_pc_o),
    .fetch_instr_o     (fetch_instr_o),
    .fetch_reason_o    (fetch_reason_o)
  );

endmodule

`default_nettype wire

/* hdl/fetch_npc.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_npc #(
  parameter int unsigned AddrLen = fetch_pkg::AddrLen
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               redirect_valid_i,
  input  logic [AddrLen-1:0] redirect_pc_i,
  input  logic               predict_taken_i,
  input  logic [AddrLen-1:0] predict_target_i,
  input  logic               predict_partial_i,
  fetch_slot_if.npc          slot,
  output logic [AddrLen-1:0] npc_o,
  output logic               imem_req_valid_o,
  output logic [AddrLen-1:0] imem_req_pc_o
);

  import fetch_pkg::*;

  logic               advance;
  logic               redirect_q;
  logic [AddrLen-1:0] redirect_pc_q;
  logic               slot_valid_q;
  logic [AddrLen-1:0] pc_q;
  fetch_reason_e      reason_q;
  fetch_reason_e      reason_d;
  logic [AddrLen-1:0] seq_pc;

  assign advance = slot.slot_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Redirect latch
  ////////////////////////////////////////////////////////////////////////////

  // The reset vector is held as a pending redirect to address zero.
  // A new pulse wins over the clear from an advance in the same cycle.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      redirect_q    <= 1'b1;
      redirect_pc_q <= '0;
    end else begin
      if (advance) begin
        redirect_q <= 1'b0;
      end
      if (redirect_valid_i) begin
        redirect_q    <= 1'b1;
        redirect_pc_q <= redirect_pc_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next PC selection
  ////////////////////////////////////////////////////////////////////////////

  assign seq_pc = {pc_q[AddrLen-1:2], 2'b00} + AddrLen'(4);

  always_comb begin
    if (redirect_q) begin
      npc_o    = {redirect_pc_q[AddrLen-1:1], 1'b0};
      reason_d = FETCH_REDIRECT;
    end else if (predict_taken_i) begin
      npc_o    = predict_target_i;
      reason_d = FETCH_PREDICT;
    end else begin
      npc_o    = seq_pc;
      reason_d = FETCH_PREFETCH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_valid_q <= 1'b0;
      pc_q         <= '0;
      reason_q     <= FETCH_PREFETCH;
    end else if (advance) begin
      slot_valid_q <= 1'b1;
      pc_q         <= npc_o;
      reason_q     <= reason_d;
    end
  end

  assign slot.slot_valid  = slot_valid_q;
  assign slot.slot_pc     = pc_q;
  assign slot.slot_reason = reason_q;

  // Upper half only after a jump into the middle of a word, lower half only
  // when a predicted branch there leaves the rest of the word.
  assign slot.slot_strb = pc_q[1] ? 2'b10 :
                          (predict_taken_i && predict_partial_i) ? 2'b01 : 2'b11;

  // The memory is always asked for the whole word.
  assign imem_req_valid_o = advance;
  assign imem_req_pc_o    = {npc_o[AddrLen-1:2], 2'b00};

endmodule

`default_nettype wire

/* hdl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // Defaults for the top level, which passes its own values down.
  localparam int unsigned AddrLen       = 39;
  localparam int unsigned BtbIndexWidth = 5;
  localparam int unsigned BhtIndexWidth = 7;

  // Why a fetch word was requested.
  typedef enum logic [1:0] {
    FETCH_PREFETCH = 2'b00,
    FETCH_PREDICT  = 2'b01,
    FETCH_REDIRECT = 2'b10
  } fetch_reason_e;

  // Bit 0 marks a taken transfer and bit 2 an unconditional one.
  typedef enum logic [2:0] {
    BRANCH_NONE    = 3'b000,
    BRANCH_UNTAKEN = 3'b010,
    BRANCH_TAKEN   = 3'b011,
    BRANCH_JUMP    = 3'b101
  } branch_type_e;

  // A fetch word seen as one full instruction or as two 16-bit parcels.
  typedef union packed {
    logic [31:0] word;
    struct packed {
      logic [15:0] upper;
      logic [15:0] lower;
    } half;
  } fetch_word_u;

  // A parcel whose two lowest bits are set starts a 32-bit instruction.
  function automatic logic is_full_instr(logic [15:0] parcel);
    return parcel[1:0] == 2'b11;
  endfunction

endpackage

`default_nettype wire

/* hdl/fetch_predictor.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_predictor #(
  parameter int unsigned AddrLen       = fetch_pkg::AddrLen,
  parameter int unsigned BtbIndexWidth = fetch_pkg::BtbIndexWidth,
  parameter int unsigned BhtIndexWidth = fetch_pkg::BhtIndexWidth
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    lookup_valid_i,
  input  logic [AddrLen-1:0]      lookup_pc_i,
  input  logic [AddrLen-1:0]      slot_pc_i,
  input  fetch_pkg::branch_type_e branch_type_i,
  input  logic [AddrLen-1:0]      branch_pc_i,
  input  logic [AddrLen-1:0]      redirect_pc_i,
  output logic                    predict_taken_o,
  output logic [AddrLen-1:0]      predict_target_o,
  output logic                    predict_partial_o
);

  import fetch_pkg::*;

  localparam int unsigned BtbEntries = 2 ** BtbIndexWidth;
  localparam int unsigned BhtEntries = 2 ** BhtIndexWidth;
  localparam int unsigned TagWidth   = AddrLen - BtbIndexWidth - 2;

  logic [BtbEntries-1:0] btb_valid_q;
  logic [TagWidth-1:0]   btb_tag_q     [BtbEntries];
  branch_type_e          btb_type_q    [BtbEntries];
  logic [AddrLen-1:0]    btb_target_q  [BtbEntries];
  logic                  btb_partial_q [BtbEntries];
  logic [1:0]            bht_q         [BhtEntries];

  logic                     btb_train;
  logic                     bht_train;
  logic                     train_partial;
  logic [BtbIndexWidth-1:0] train_btb_idx;
  logic [BtbIndexWidth-1:0] look_btb_idx;
  logic [BhtIndexWidth-1:0] train_bht_idx;
  logic [BhtIndexWidth-1:0] look_bht_idx;
  logic [1:0]               bht_next;

  logic               hit_q;
  branch_type_e       type_q;
  logic [AddrLen-1:0] target_q;
  logic               partial_q;
  logic [1:0]         ctr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Training
  ////////////////////////////////////////////////////////////////////////////

  assign btb_train     = branch_type_i[2] || branch_type_i[0];
  assign bht_train     = branch_type_i inside {BRANCH_UNTAKEN, BRANCH_TAKEN};
  assign train_btb_idx = branch_pc_i[BtbIndexWidth+1:2];
  assign train_bht_idx = branch_pc_i[BhtIndexWidth+1:2];

  // A branch in the lower half leaves the upper half of its word unused.
  // Branches are predicted from the word in which they start.
  assign train_partial = !branch_pc_i[1];

  always_comb begin
    bht_next = bht_q[train_bht_idx];
    if (branch_type_i[0]) begin
      if (bht_next != 2'b11) bht_next = bht_next + 2'b01;
    end else if (bht_next != 2'b00) begin
      bht_next = bht_next - 2'b01;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      btb_valid_q <= '0;
    end else if (btb_train) begin
      btb_valid_q[train_btb_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (btb_train) begin
      btb_tag_q[train_btb_idx]     <= branch_pc_i[AddrLen-1:BtbIndexWidth+2];
      btb_type_q[train_btb_idx]    <= branch_type_i;
      btb_target_q[train_btb_idx]  <= {redirect_pc_i[AddrLen-1:1], 1'b0};
      btb_partial_q[train_btb_idx] <= train_partial;
    end
  end

  // Counters start weakly not-taken.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < BhtEntries; i++) begin
        bht_q[i] <= 2'b01;
      end
    end else if (bht_train) begin
      bht_q[train_bht_idx] <= bht_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////////////////////

  assign look_btb_idx = lookup_pc_i[BtbIndexWidth+1:2];
  assign look_bht_idx = lookup_pc_i[BhtIndexWidth+1:2];

  // The lookup is taken with the slot, so its result describes the current word.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hit_q <= 1'b0;
    end else if (lookup_valid_i) begin
      hit_q <= btb_valid_q[look_btb_idx] &&
               btb_tag_q[look_btb_idx] == lookup_pc_i[AddrLen-1:BtbIndexWidth+2];
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_valid_i) begin
      type_q    <= btb_type_q[look_btb_idx];
      target_q  <= btb_target_q[look_btb_idx];
      partial_q <= btb_partial_q[look_btb_idx];
      ctr_q     <= bht_q[look_bht_idx];
    end
  end

  // A slot entered at the upper half skips a branch held in the lower half.
  assign predict_taken_o   = hit_q && !(slot_pc_i[1] && partial_q) && (type_q[2] || ctr_q[1]);
  assign predict_target_o  = target_q;
  assign predict_partial_o = partial_q;

endmodule

`default_nettype wire

/* hdl/fetch_slot_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface fetch_slot_if #(
  parameter int unsigned AddrLen = fetch_pkg::AddrLen
) ();

  import fetch_pkg::*;

  logic               slot_valid;
  logic [AddrLen-1:0] slot_pc;
  fetch_reason_e      slot_reason;
  // One bit per half of the word that may start an instruction.
  logic [1:0]         slot_strb;
  logic               slot_ready;

  modport npc (
    output slot_valid,
    output slot_pc,
    output slot_reason,
    output slot_strb,
    input  slot_ready
  );

  modport align (
    input  slot_valid,
    input  slot_pc,
    input  slot_reason,
    input  slot_strb,
    output slot_ready
  );

endinterface

`default_nettype wire

/* tb/fetch_frontend_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_frontend_properties #(
  parameter int unsigned AddrLen = fetch_pkg::AddrLen
) (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     imem_req_valid_o,
  input logic                     imem_resp_valid_i,
  input logic                     redirect_valid_i,
  input logic                     fetch_valid_o,
  input logic                     fetch_ready_i,
  input logic [AddrLen-1:0]       fetch_pc_o,
  input logic [31:0]              fetch_instr_o,
  input fetch_pkg::fetch_reason_e fetch_reason_o
);

  int unsigned failures = 0;

  // An offered instruction waits for its transfer, unless a redirect drops it.
  property fetch_held_p;
    @(posedge clk_i) disable iff (!rst_ni)
      fetch_valid_o && !fetch_ready_i |=>
        redirect_valid_i || (fetch_valid_o && $stable(fetch_pc_o) &&
                             $stable(fetch_instr_o) && $stable(fetch_reason_o));
  endproperty

  // The memory answers exactly one cycle after an accepted request.
  property resp_after_req_p;
    @(posedge clk_i) disable iff (!rst_ni)
      imem_resp_valid_i |-> $past(imem_req_valid_o);
  endproperty

  property quiet_in_reset_p;
    @(posedge clk_i) !rst_ni |-> !fetch_valid_o && !imem_req_valid_o;
  endproperty

  held_a: assert property (fetch_held_p)
    else begin
      failures++;
      $error("Fetch outputs changed before the instruction was accepted");
    end

  resp_a: assert property (resp_after_req_p)
    else begin
      failures++;
      $error("Memory response arrived without a request in the cycle before");
    end

  reset_a: assert property (quiet_in_reset_p)
    else begin
      failures++;
      $error("An output was valid while reset was asserted");
    end

endmodule

`default_nettype wire

/* tb/fetch_frontend_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_frontend_tb;

  import fetch_pkg::*;

  localparam int unsigned AddrLen        = 39;
  localparam int unsigned ClkPeriod      = 8;
  localparam int unsigned SeqCount       = 300;
  localparam int unsigned RedirectRounds = 40;
  localparam int unsigned PredictRounds  = 12;
  localparam int unsigned UntakenRounds  = 6;
  // Upper bound on the transfers in one redirect or training round.
  localparam int unsigned RoundBudget    = 48;
  localparam int unsigned ExpectedInstr  =
    SeqCount + (RedirectRounds + PredictRounds + UntakenRounds) * RoundBudget;
  localparam longint unsigned TimeoutNs  = longint'(ExpectedInstr) * 20 * ClkPeriod;

  logic               clk_i;
  logic               rst_ni;
  logic               imem_req_valid_o;
  logic [AddrLen-1:0] imem_req_pc_o;
  logic               imem_resp_valid_i;
  logic [31:0]        imem_resp_instr_i;
  logic               redirect_valid_i;
  logic [AddrLen-1:0] redirect_pc_i;
  branch_type_e       branch_type_i;
  logic [AddrLen-1:0] branch_pc_i;
  logic               fetch_valid_o;
  logic               fetch_ready_i;
  logic [AddrLen-1:0] fetch_pc_o;
  logic [31:0]        fetch_instr_o;
  fetch_reason_e      fetch_reason_o;

  // Instruction memory of 512 half-words, addressed modulo 1 KiB.
  logic [15:0]        mem [512];
  logic               req_seen_q;
  logic [AddrLen-1:0] req_pc_q;

  logic [AddrLen-1:0] exp_pc;
  fetch_reason_e      exp_reason;
  logic               pred_armed;
  logic [AddrLen-1:0] pred_x;
  logic [AddrLen-1:0] pred_t;
  int unsigned        error_count;
  int unsigned        xfer_count;

  fetch_frontend #(
    .AddrLen (AddrLen)
  ) fetch_frontend_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .imem_req_valid_o  (imem_req_valid_o),
    .imem_req_pc_o     (imem_req_pc_o),
    .imem_resp_valid_i (imem_resp_valid_i),
    .imem_resp_instr_i (imem_resp_instr_i),
    .redirect_valid_i  (redirect_valid_i),
    .redirect_pc_i     (redirect_pc_i),
    .branch_type_i     (branch_type_i),
    .branch_pc_i       (branch_pc_i),
    .fetch_valid_o     (fetch_valid_o),
    .fetch_ready_i     (fetch_ready_i),
    .fetch_pc_o        (fetch_pc_o),
    .fetch_instr_o     (fetch_instr_o),
    .fetch_reason_o    (fetch_reason_o)
  );

  bind fetch_frontend fetch_frontend_properties #(
    .AddrLen (AddrLen)
  ) fetch_frontend_properties_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .imem_req_valid_o  (imem_req_valid_o),
    .imem_resp_valid_i (imem_resp_valid_i),
    .redirect_valid_i  (redirect_valid_i),
    .fetch_valid_o     (fetch_valid_o),
    .fetch_ready_i     (fetch_ready_i),
    .fetch_pc_o        (fetch_pc_o),
    .fetch_instr_o     (fetch_instr_o),
    .fetch_reason_o    (fetch_reason_o)
  );

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] half_at(logic [AddrLen-1:0] pc);
    return mem[pc[9:1]];
  endfunction

  function automatic int unsigned instr_len(logic [AddrLen-1:0] pc);
    logic [15:0] first;
    first = half_at(pc);
    return (first[1:0] == 2'b11) ? 4 : 2;
  endfunction

  // Compressed instructions are delivered zero-extended.
  function automatic logic [31:0] instr_at(logic [AddrLen-1:0] pc);
    logic [15:0] first;
    first = half_at(pc);
    if (first[1:0] == 2'b11) begin
      return {half_at(pc + AddrLen'(2)), first};
    end
    return {16'h0000, first};
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("Error: %s is %h, expected %h at %0t ns", name, actual, expected, $time);
    end
  endtask

  // Whatever is offered must be the next instruction of the stream.
  always @(posedge clk_i) begin
    if (rst_ni && fetch_valid_o) begin
      check_value("fetch_pc_o", fetch_pc_o, exp_pc);
      check_value("fetch_instr_o", fetch_instr_o, instr_at(exp_pc));
      check_value("fetch_reason_o", fetch_reason_o, exp_reason);
      if (fetch_ready_i) begin
        if (pred_armed && exp_pc == pred_x) begin
          exp_pc     = pred_t;
          exp_reason = FETCH_PREDICT;
          pred_armed = 1'b0;
        end else begin
          exp_pc     = exp_pc + AddrLen'(instr_len(exp_pc));
          exp_reason = FETCH_PREFETCH;
        end
        xfer_count++;
      end
    end
  end

  // Memory answers one cycle after each accepted request.
  always @(posedge clk_i) begin
    req_seen_q <= imem_req_valid_o;
    req_pc_q   <= imem_req_pc_o;
  end

  always @(negedge clk_i) begin
    imem_resp_valid_i <= req_seen_q;
    imem_resp_instr_i <= {mem[{req_pc_q[9:2], 1'b1}], mem[{req_pc_q[9:2], 1'b0}]};
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic fill_memory();
    logic [15:0] parcel;
    for (int i = 0; i < 512; i++) begin
      parcel = 16'($urandom);
      if ($urandom_range(1) == 1) begin
        parcel[1:0] = 2'($urandom_range(2));
      end else begin
        parcel[1:0] = 2'b11;
      end
      mem[i] = parcel;
    end
  endtask

  task automatic wait_transfers(input int unsigned count);
    int unsigned goal;
    goal = xfer_count + count;
    while (xfer_count < goal) @(negedge clk_i);
  endtask

  task automatic send_redirect(input logic [AddrLen-1:0] target);
    redirect_valid_i = 1'b1;
    redirect_pc_i    = target;
    exp_pc           = {target[AddrLen-1:1], 1'b0};
    exp_reason       = FETCH_REDIRECT;
    pred_armed       = 1'b0;
    @(negedge clk_i);
    redirect_valid_i = 1'b0;
  endtask

  task automatic report_branch(input branch_type_e kind, input logic [AddrLen-1:0] pc,
                               input logic [AddrLen-1:0] target, input int unsigned cycles);
    branch_type_i = kind;
    branch_pc_i   = pc;
    redirect_pc_i = target;
    repeat (cycles) @(negedge clk_i);
    branch_type_i = BRANCH_NONE;
  endtask

  // Pick an instruction well ahead of the stream that ends inside its own word.
  task automatic find_branch_site(output logic [AddrLen-1:0] site,
                                  output int unsigned steps);
    site  = exp_pc;
    steps = 0;
    repeat (8) begin
      site = site + AddrLen'(instr_len(site));
      steps++;
    end
    while (site[1] && instr_len(site) == 4) begin
      site = site + AddrLen'(instr_len(site));
      steps++;
    end
  endtask

  initial begin
    logic [AddrLen-1:0] site;
    logic [AddrLen-1:0] target;
    int unsigned        steps;
    void'($urandom(32'h13b6));
    rst_ni            = 1'b0;
    fetch_ready_i     = 1'b0;
    redirect_valid_i  = 1'b0;
    redirect_pc_i     = '0;
    branch_type_i     = BRANCH_NONE;
    branch_pc_i       = '0;
    imem_resp_valid_i = 1'b0;
    imem_resp_instr_i = '0;
    error_count       = 0;
    xfer_count        = 0;
    exp_pc            = '0;
    exp_reason        = FETCH_REDIRECT;
    pred_armed        = 1'b0;
    pred_x            = '0;
    pred_t            = '0;
    fill_memory();

    // The back end takes an instruction in about 70 % of the cycles.
    fork
      forever begin
        @(negedge clk_i);
        fetch_ready_i <= ($urandom_range(99) < 70);
      end
    join_none

    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    wait_transfers(SeqCount);

    // Targets always lie ahead, so no trained entry is ever met again.
    repeat (RedirectRounds) begin
      wait_transfers($urandom_range(8, 1));
      repeat ($urandom_range(3)) @(negedge clk_i);
      send_redirect(exp_pc + AddrLen'(32 + $urandom_range(255)));
    end
    wait_transfers(4);

    repeat (PredictRounds) begin
      find_branch_site(site, steps);
      target     = site + AddrLen'(64 + 2 * $urandom_range(127));
      pred_x     = site;
      pred_t     = target;
      pred_armed = 1'b1;
      report_branch(BRANCH_JUMP, site, target, 1);
      wait_transfers(steps + 4);
    end

    // The entry is installed by a taken report and then walked down by two untaken ones.
    repeat (UntakenRounds) begin
      find_branch_site(site, steps);
      report_branch(BRANCH_TAKEN, site, site + AddrLen'(128), 1);
      report_branch(BRANCH_UNTAKEN, site, site + AddrLen'(128), 2);
      wait_transfers(steps + 3);
    end

    $display("Checked %0d transfers: %0d errors, %0d assertion failures", xfer_count,
             error_count, fetch_frontend_i.fetch_frontend_properties_i.failures);
    if (error_count == 0 && fetch_frontend_i.fetch_frontend_properties_i.failures == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TimeoutNs);
    $display("Timeout: the fetch stream stopped after %0d transfers, %0d errors",
             xfer_count, error_count);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
